// ==== sim.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_memory.sv
logic/rv_core_top.sv
bench/rv_core_tb.sv

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_ROWS     = 16;
  localparam int HOLD_CYCLES  = 10;
  // two runs of reset, program and stopped hold, plus slack
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + MAX_ROWS + HOLD_CYCLES) + 20;

  logic                clk;
  logic                reset;
  rv_load_t            load;
  logic [`RV_XLEN-1:0] current_pc;
  logic [`RV_XLEN-1:0] next_pc;
  logic                halted;
  logic                illegal;
  rv_retire_t          retire;

  // program image, one word per row, and the record each word should retire
  logic [31:0] prog_word [MAX_ROWS];
  rv_retire_t  prog_exp [MAX_ROWS];
  int          n_rows;

  rv_core_top rv_core_top_i (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .halted     (halted),
    .illegal    (illegal),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // encoders per instruction format
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input rv_opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // sd only, funct3 fixed
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input rv_opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // successor of a row is the next row that retires, else the word after it
  function automatic logic [63:0] successor_pc(input int row);
    int j;
    for (j = row + 1; j < n_rows; j++) begin
      if (prog_exp[j].valid) begin
        return prog_exp[j].pc;
      end
    end
    return prog_exp[row].pc + 64'd4;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // next word at pc = row * 4
  task automatic add_row(input logic [31:0] word, input logic valid, input logic [4:0] rd,
                         input logic [63:0] wdata, input logic wen);
    prog_word[n_rows]      = word;
    prog_exp[n_rows].valid = valid;
    prog_exp[n_rows].pc    = n_rows * 4;
    prog_exp[n_rows].rd    = rd;
    prog_exp[n_rows].wdata = wdata;
    prog_exp[n_rows].wen   = wen;
    n_rows++;
  endtask

  // lui then addi, rv64 sign extension at each step
  task automatic add_li(input logic [4:0] rd, input logic [31:0] value,
                        output logic [63:0] reg_value);
    reg_value = {{32{value[31]}}, value[31:12], 12'h0};
    add_row(enc_u(value[31:12], rd, op_lui), 1'b1, rd, reg_value, 1'b1);
    reg_value = reg_value + {{52{value[11]}}, value[11:0]};
    add_row(enc_i(value[11:0], rd, 3'b000, rd, op_imm), 1'b1, rd, reg_value, 1'b1);
  endtask

  // alu forms, x0 write, sd/ld round trip, ebreak
  task automatic build_alu_program;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] x1;
    logic [63:0] x2;
    n_rows = 0;
    a = lcg_next(32'h0cf2_6022);
    b = lcg_next(a);
    add_li(5'd1, a, x1);
    add_li(5'd2, b, x2);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, x1 + x2, 1'b1);
    add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, x1 - x2, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1'b1, 5'd5, x1 & x2, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1'b1, 5'd6, x1 | x2, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, x1 ^ x2, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8), 1'b1, 5'd8,
            ($signed(x1) < $signed(x2)) ? 64'd1 : 64'd0, 1'b1);
    // x0 target still reports its write
    add_row(enc_i(12'h000, 5'd1, 3'b000, 5'd0, op_imm), 1'b1, 5'd0, x1, 1'b1);
    // x0 as base, so the address only holds if x0 stayed zero
    add_row(enc_s(12'h400, 5'd4, 5'd0), 1'b1, 5'd0, 64'h0, 1'b0);
    add_row(enc_i(12'h400, 5'd0, 3'b011, 5'd9, op_load), 1'b1, 5'd9, x1 - x2, 1'b1);
    add_row(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd10), 1'b1, 5'd10, x2, 1'b1);
    add_row(32'h0010_0073, 1'b1, 5'd0, 64'h0, 1'b0);
    // past the ebreak, never fetched for retire
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd11, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
  endtask

  // branches, auipc, jumps, then an unsupported opcode
  task automatic build_branch_program;
    n_rows = 0;
    add_row(enc_i(12'h005, 5'd0, 3'b000, 5'd1, op_imm), 1'b1, 5'd1, 64'd5, 1'b1);
    // beq taken over the filler
    add_row(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 1'b1, 5'd0, 64'h0, 1'b0);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd2, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
    // bne not taken, falls through to the auipc
    add_row(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 1'b1, 5'd0, 64'h0, 1'b0);
    // pc 0x10 plus 0x1000
    add_row(enc_u(20'h00001, 5'd2, op_auipc), 1'b1, 5'd2, 64'h1010, 1'b1);
    // jal at pc 0x14 links 0x18, lands on 0x1c
    add_row(enc_j(21'd8, 5'd3), 1'b1, 5'd3, 64'h18, 1'b1);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd2, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
    // 5 + 0x24 = 0x29, bit 0 dropped gives 0x28
    add_row(enc_i(12'h024, 5'd1, 3'b000, 5'd4, op_jalr), 1'b1, 5'd4, 64'h20, 1'b1);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd2, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd2, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
    // custom-0 opcode
    add_row(32'h0000_000b, 1'b1, 5'd0, 64'h0, 1'b0);
    add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd5, op_imm), 1'b0, 5'd0, 64'h0, 1'b0);
  endtask

  task automatic run_program(input logic expect_halt);
    int          i;
    int          row;
    logic [63:0] held_pc;
    // load one word per reset cycle
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      reset     = 1'b1;
      load.we   = (i < n_rows);
      load.addr = i[RV_MEM_AW-1:0];
      load.data = prog_word[i];
    end
    @(negedge clk);
    check_value("current_pc", current_pc, `RV_PC_RESET);
    check_value("halted", halted, 1'b0);
    check_value("illegal", illegal, 1'b0);
    check_value("retire.valid", retire.valid, 1'b0);
    reset = 1'b0;
    load  = '0;
    for (row = 0; row < n_rows; row++) begin
      if (prog_exp[row].valid) begin
        // this row is fetched now and executes at the next rising edge
        check_value("current_pc", current_pc, prog_exp[row].pc);
        check_value("next_pc", next_pc, successor_pc(row));
        @(negedge clk);
        while (!retire.valid) begin
          @(negedge clk);
        end
        check_value("retire.pc", retire.pc, prog_exp[row].pc);
        check_value("retire.wen", retire.wen, prog_exp[row].wen);
        // rd and wdata carry meaning only with a register write
        if (prog_exp[row].wen) begin
          check_value("retire.rd", retire.rd, prog_exp[row].rd);
          check_value("retire.wdata", retire.wdata, prog_exp[row].wdata);
        end
      end
    end
    // stop flag rises with the last record
    check_value("halted", halted, expect_halt);
    check_value("illegal", illegal, !expect_halt);
    held_pc = current_pc;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("retire.valid", retire.valid, 1'b0);
      check_value("current_pc", current_pc, held_pc);
    end
  endtask

  initial begin
    reset  = 1'b1;
    load   = '0;
    n_rows = 0;
    build_alu_program();
    run_program(1'b1);
    // second run from a fresh reset
    build_branch_program();
    run_program(1'b0);
    $display("Verification passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the core never halted", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_top import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire rv_load_t            load,
  output logic      [`RV_XLEN-1:0] current_pc,
  output logic      [`RV_XLEN-1:0] next_pc,
  output logic                     halted,
  output logic                     illegal,
  output rv_retire_t               retire
);

  logic [31:0]             inst;
  logic [`RV_REG_ID_W-1:0] rd;
  logic [`RV_REG_ID_W-1:0] rs1;
  logic [`RV_REG_ID_W-1:0] rs2;
  logic [`RV_XLEN-1:0]     imm;
  rv_ctrl_t                ctrl;
  logic [`RV_XLEN-1:0]     rdata_1;
  logic [`RV_XLEN-1:0]     rdata_2;
  logic [`RV_XLEN-1:0]     operand_1;
  logic [`RV_XLEN-1:0]     operand_2;
  logic [`RV_XLEN-1:0]     alu_result;
  logic [`RV_XLEN-1:0]     mem_rdata;
  logic [`RV_XLEN-1:0]     wb_data;
  logic [`RV_XLEN-1:0]     pc_plus_4;
  logic                    is_jump;
  logic                    branch_taken;
  logic                    running;
  logic                    advance;

  // core executes only between reset and the first halt or trap
  assign running = ~reset & ~halted & ~illegal;
  // ebreak and traps keep the pc on the offending word
  assign advance = running & ~ctrl.is_ebreak & ~ctrl.illegal;

  rv_memory rv_memory_i (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .pc         (current_pc),
    .data_addr  (alu_result),
    .data_wdata (rdata_2),
    .data_wen   (ctrl.is_store & running),
    .inst       (inst),
    .data_rdata (mem_rdata)
  );

  rv_decoder rv_decoder_i (
    .inst (inst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  rv_regfile rv_regfile_i (
    .clk     (clk),
    .wen     (ctrl.reg_wen & running),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .wdata   (wb_data),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // pc-relative forms take the pc as operand 1
  assign operand_1 = (ctrl.is_auipc | ctrl.is_jal) ? current_pc : rdata_1;
  assign operand_2 = ctrl.need_imm ? imm : rdata_2;

  rv_alu rv_alu_i (
    .operand_1  (operand_1),
    .operand_2  (operand_2),
    .alu_op     (ctrl.alu_op),
    .alu_result (alu_result)
  );

  assign pc_plus_4    = current_pc + `RV_INST_BYTES;
  assign is_jump      = ctrl.is_jal | ctrl.is_jalr;
  assign branch_taken = ctrl.is_branch & (alu_result == 1);

  // link address, load data or alu result
  assign wb_data = is_jump ? pc_plus_4 : (ctrl.is_load ? mem_rdata : alu_result);

  // jump target always has bit 0 cleared, harmless for jal
  assign next_pc = is_jump      ? {alu_result[`RV_XLEN-1:1], 1'b0} :
                   branch_taken ? current_pc + imm :
                                  pc_plus_4;

  always_ff @(posedge clk) begin
    if (reset) begin
      current_pc <= `RV_PC_RESET;
    end else if (advance) begin
      current_pc <= next_pc;
    end
  end

  // sticky stop flags
  always_ff @(posedge clk) begin
    if (reset) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (running) begin
      halted  <= ctrl.is_ebreak;
      illegal <= ctrl.illegal;
    end
  end

  // retire record one cycle after the instruction executes
  // only valid carries reset
  always_ff @(posedge clk) begin
    retire.pc    <= current_pc;
    retire.rd    <= rd;
    retire.wdata <= wb_data;
    retire.wen   <= ctrl.reg_wen;
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= running;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_memory import rv_pkg::*; (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire rv_load_t            load,
  input  wire logic [`RV_XLEN-1:0] pc,
  input  wire logic [`RV_XLEN-1:0] data_addr,
  input  wire logic [`RV_XLEN-1:0] data_wdata,
  input  wire logic                data_wen,
  output logic      [31:0]         inst,
  output logic      [`RV_XLEN-1:0] data_rdata
);

  // doubleword index width, one bit less than the word index
  localparam int unsigned DW_AW = RV_MEM_AW - 1;

  logic [31:0]          mem [`RV_MEM_WORDS];
  logic [RV_MEM_AW-1:0] fetch_idx;
  logic [DW_AW-1:0]     dw_idx;
  logic [RV_MEM_AW-1:0] lo_idx;
  logic [RV_MEM_AW-1:0] hi_idx;

  // pc is word aligned, drop the byte offset
  assign fetch_idx = pc[RV_MEM_AW+1:2];

  // doubleword aligned access
  // address bit 2 is always 0 here, so the pair is {idx,0} and {idx,1}
  assign dw_idx = data_addr[RV_MEM_AW+1:3];
  assign lo_idx = {dw_idx, 1'b0};
  assign hi_idx = {dw_idx, 1'b1};

  // instruction fetch, combinational
  assign inst = mem[fetch_idx];

  // little endian, low word at the lower address
  assign data_rdata = {mem[hi_idx], mem[lo_idx]};

  // program load during reset
  // otherwise store both halves of the doubleword at one edge
  always_ff @(posedge clk) begin
    if (reset) begin
      if (load.we) begin
        mem[load.addr] <= load.data;
      end
    end else if (data_wen) begin
      mem[lo_idx] <= data_wdata[31:0];
      mem[hi_idx] <= data_wdata[63:32];
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
  input  wire logic                    clk,
  input  wire logic                    wen,
  input  wire logic [`RV_REG_ID_W-1:0] rd,
  input  wire logic [`RV_REG_ID_W-1:0] rs1,
  input  wire logic [`RV_REG_ID_W-1:0] rs2,
  input  wire logic [`RV_XLEN-1:0]     wdata,
  output logic      [`RV_XLEN-1:0]     rdata_1,
  output logic      [`RV_XLEN-1:0]     rdata_2
);

  localparam int unsigned NUM_REGS = 1 << `RV_REG_ID_W;

  logic [`RV_XLEN-1:0] regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads zero even though its entry is never initialised
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_alu import rv_pkg::*; (
  input  wire logic [`RV_XLEN-1:0] operand_1,
  input  wire logic [`RV_XLEN-1:0] operand_2,
  input  wire rv_alu_op_e          alu_op,
  output logic      [`RV_XLEN-1:0] alu_result
);

  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  // shared comparators for slt, sltu and the branches
  assign lt_signed   = $signed(operand_1) < $signed(operand_2);
  assign lt_unsigned = operand_1 < operand_2;
  assign equal       = operand_1 == operand_2;

  always_comb begin
    case (alu_op)
      alu_add:    alu_result = operand_1 + operand_2;
      alu_sub:    alu_result = operand_1 - operand_2;
      alu_and:    alu_result = operand_1 & operand_2;
      alu_or:     alu_result = operand_1 | operand_2;
      alu_xor:    alu_result = operand_1 ^ operand_2;
      // comparisons land in bit 0
      alu_slt:    alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      alu_sltu:   alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      // lui
      alu_pass_b: alu_result = operand_2;
      // branch conditions, 1 means taken
      alu_eq:     alu_result = {{(`RV_XLEN-1){1'b0}}, equal};
      alu_ne:     alu_result = {{(`RV_XLEN-1){1'b0}}, ~equal};
      alu_lt:     alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      alu_ge:     alu_result = {{(`RV_XLEN-1){1'b0}}, ~lt_signed};
      default:    alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
  input  wire logic [31:0]             inst,
  output logic      [`RV_REG_ID_W-1:0] rd,
  output logic      [`RV_REG_ID_W-1:0] rs1,
  output logic      [`RV_REG_ID_W-1:0] rs2,
  output logic      [`RV_XLEN-1:0]     imm,
  output rv_ctrl_t                     ctrl
);

  // the only system encoding we accept
  localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign opcode = rv_opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions in every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // sign-extended immediates, one per format
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    imm         = imm_i;
    case (opcode)
      op_lui: begin
        // imm passes straight through the alu
        imm           = imm_u;
        ctrl.alu_op   = alu_pass_b;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
      end
      op_auipc: begin
        imm           = imm_u;
        ctrl.need_imm = 1'b1;
        ctrl.is_auipc = 1'b1;
        ctrl.reg_wen  = 1'b1;
      end
      op_jal: begin
        // alu computes pc + imm as the target
        imm           = imm_j;
        ctrl.need_imm = 1'b1;
        ctrl.is_jal   = 1'b1;
        ctrl.reg_wen  = 1'b1;
      end
      op_jalr: begin
        ctrl.need_imm = 1'b1;
        ctrl.is_jalr  = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.illegal  = (funct3 != 3'b000);
      end
      op_branch: begin
        // condition from rs1 vs rs2, target added in the top
        imm            = imm_b;
        ctrl.is_branch = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = alu_eq;
          3'b001:  ctrl.alu_op = alu_ne;
          3'b100:  ctrl.alu_op = alu_lt;
          3'b101:  ctrl.alu_op = alu_ge;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      op_load: begin
        // ld only
        ctrl.need_imm = 1'b1;
        ctrl.is_load  = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.illegal  = (funct3 != 3'b011);
      end
      op_store: begin
        // sd only
        imm           = imm_s;
        ctrl.need_imm = 1'b1;
        ctrl.is_store = 1'b1;
        ctrl.illegal  = (funct3 != 3'b011);
      end
      op_imm: begin
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = alu_add;
          3'b010:  ctrl.alu_op = alu_slt;
          3'b011:  ctrl.alu_op = alu_sltu;
          3'b100:  ctrl.alu_op = alu_xor;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          // shifts are not supported
          default: ctrl.illegal = 1'b1;
        endcase
      end
      op_reg: begin
        ctrl.reg_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
          {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
          {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
          {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
          {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
          {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
          {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
          default:              ctrl.illegal = 1'b1;
        endcase
      end
      op_system: begin
        // no csr access, ebreak alone
        ctrl.is_ebreak = (inst == EBREAK_INST);
        ctrl.illegal   = (inst != EBREAK_INST);
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
    // an unsupported encoding must not write or jump anywhere
    if (ctrl.illegal) begin
      ctrl         = '0;
      ctrl.alu_op  = alu_add;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  // word index width of the unified memory
  localparam int unsigned RV_MEM_AW = $clog2(`RV_MEM_WORDS);

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } rv_opcode_e;

  // alu operations
  // the branch conditions reuse the comparator and return 0 or 1
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_slt    = 4'd5,
    alu_sltu   = 4'd6,
    alu_pass_b = 4'd7,
    alu_eq     = 4'd8,
    alu_ne     = 4'd9,
    alu_lt     = 4'd10,
    alu_ge     = 4'd11
  } rv_alu_op_e;

  // decoded control for one instruction
  typedef struct packed {
    rv_alu_op_e alu_op;
    // operand 2 comes from the immediate
    logic       need_imm;
    // operand 1 comes from the pc
    logic       is_auipc;
    logic       is_jal;
    logic       is_jalr;
    logic       is_branch;
    logic       is_load;
    logic       is_store;
    logic       reg_wen;
    logic       is_ebreak;
    logic       illegal;
  } rv_ctrl_t;

  // one retired instruction as seen from outside
  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_REG_ID_W-1:0]   rd;
    logic [`RV_XLEN-1:0]       wdata;
    logic                      wen;
  } rv_retire_t;

  // program load strobe, honoured only during reset
  typedef struct packed {
    logic                 we;
    logic [RV_MEM_AW-1:0] addr;
    logic [31:0]          data;
  } rv_load_t;

endpackage

`default_nettype wire

// ==== logic/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and address width
`define RV_XLEN 64

// register index width, 32 integer registers
`define RV_REG_ID_W 5

// memory depth in 32-bit words
// 1024 words gives 4 KiB, so the word index is pc[11:2]
`define RV_MEM_WORDS 1024

// first fetch address after reset
`define RV_PC_RESET 64'h0

// fixed instruction size in bytes
`define RV_INST_BYTES 4

`endif
